/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [7:0]                 stackBus,
    input  logic [7:0]                 dataBus,
    input  logic                       psrCarry,
    input  dataflowPkg::controlFlags_t flags,
    output logic [7:0]                 result,
    output logic                       carryOut,
    output logic                       overflow
);

    logic [7:0] aOperand, bOperand;
    logic       carryIn;
    logic [8:0] sum;

    always_comb begin
        aOperand = (flags.aSel == dataflowPkg::A_ZERO) ? 8'h00 : stackBus;
        // Subtract is an add of the complemented B
        if (flags.bInvert || flags.func == dataflowPkg::ALU_SUB) begin
            bOperand = ~dataBus;
        end else begin
            bOperand = dataBus;
        end
        case (flags.carrySel)
            dataflowPkg::CARRY_ONE: carryIn = 1'b1;
            dataflowPkg::CARRY_PSR: carryIn = psrCarry;
            default:                carryIn = 1'b0;
        endcase
    end

    assign sum = {1'b0, aOperand} + {1'b0, bOperand} + {8'h00, carryIn};

    always_comb begin
        carryOut = 1'b0;
        overflow = 1'b0;
        case (flags.func)
            dataflowPkg::ALU_ADD, dataflowPkg::ALU_SUB: begin
                result   = sum[7:0];
                carryOut = sum[8];
                // Same operand signs but a different result sign
                overflow = (aOperand[7] == bOperand[7]) && (sum[7] != aOperand[7]);
            end
            dataflowPkg::ALU_AND: result = aOperand & bOperand;
            dataflowPkg::ALU_OR:  result = aOperand | bOperand;
            dataflowPkg::ALU_XOR: result = aOperand ^ bOperand;
            dataflowPkg::ALU_SHR: begin
                result   = {1'b0, aOperand[7:1]};
                carryOut = aOperand[0]; // Bit shifted out
            end
            default: result = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

/* design/busBridge.sv */
`timescale 1ns/1ps
`default_nettype none

module busBridge (
    input  logic [7:0]                 dbIn,
    input  logic [7:0]                 sbIn,
    input  logic [7:0]                 adhIn,
    input  dataflowPkg::controlFlags_t flags,
    output logic [7:0]                 dataBus,
    output logic [7:0]                 stackBus,
    output logic [7:0]                 addressHighBus
);

    logic [7:0] dbIntoSb, adhIntoSb;

    // SB sits in the middle, so DB and ADH only meet through it
    assign dbIntoSb  = flags.dbToSb ? dbIn : 8'h00;
    assign adhIntoSb = flags.adhToSb ? adhIn : 8'h00;

    assign stackBus       = sbIn | dbIntoSb | adhIntoSb;
    assign dataBus        = dbIn | (flags.sbToDb ? (sbIn | adhIntoSb) : 8'h00);
    assign addressHighBus = adhIn | (flags.sbToAdh ? (sbIn | dbIntoSb) : 8'h00);

endmodule

`default_nettype wire

/* design/dataflowPkg.sv */
`default_nettype none

package dataflowPkg;

    typedef enum logic [2:0] {
        SRC_X, SRC_Y, SRC_ACC, SRC_SP, SRC_DATA, SRC_ALU, SRC_PSR, SRC_PRESET
    } regSource_e;

    typedef enum logic [2:0] {
        DST_X, DST_Y, DST_ACC, DST_SP, DST_DOR, DST_ABL, DST_ABH, DST_PSR
    } regDest_e;

    typedef enum logic [1:0] {PRESET_FF, PRESET_FE, PRESET_FA, PRESET_00} presetSel_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_AND, ALU_OR, ALU_XOR, ALU_SHR, ALU_SUB} aluFunc_e;

    typedef enum logic [1:0] {A_X, A_Y, A_ACC, A_ZERO} aluASel_e;

    typedef enum logic [1:0] {CARRY_ZERO, CARRY_ONE, CARRY_PSR} carrySel_e;

    // Register transfer form, kind is 0
    typedef struct packed {
        logic       kind;
        regSource_e source;
        regDest_e   dest;
        presetSel_e preset;
        logic       pcInc;
        logic       pcToAddress; // ABH:ABL <= PC
        logic       pcLoad;      // PC <= ABH:ABL
    } transferOp_t;

    // ALU form, kind is 1
    typedef struct packed {
        logic      kind;
        aluFunc_e  func;
        aluASel_e  aSel;
        logic      bInvert;
        carrySel_e carrySel;
        logic      flagWrite;
        logic      pcInc;
        logic      spare;
    } aluOp_t;

    typedef union packed {
        transferOp_t transfer;
        aluOp_t      alu;
    } microOp_u;

    typedef struct packed {
        logic [5:0] dbSelect;  // PCH, PCL, ACC, PSR, DATA, PRESET
        logic [5:0] sbSelect;  // PRESET, ALU, SP, ACC, Y, X
        logic [3:0] adlSelect; // ALU, SP, DATA, PRESET
        logic [1:0] adhSelect; // DATA, PRESET
        logic       sbToDb;
        logic       dbToSb;
        logic       sbToAdh;
        logic       adhToSb;
        logic       loadX;
        logic       loadY;
        logic       loadAcc;
        logic       loadSp;
        logic       loadAlu;
        logic       loadDor;
        logic       loadAbl;
        logic       loadAbh;
        logic       loadPsr;
        logic       pcInc;
        logic       pcLoad;
        logic       pcToAddress;
        aluFunc_e   func;
        aluASel_e   aSel;
        logic       bInvert;
        carrySel_e  carrySel;
        logic       flagWrite;
        logic [7:0] presetValue;
    } controlFlags_t;

    typedef struct packed {
        logic n;
        logic v;
        logic one; // Always reads 1
        logic b;
        logic d;
        logic i;
        logic z;
        logic c;
    } psrBits_t;

endpackage

`default_nettype wire

/* design/internalBus.sv */
`timescale 1ns/1ps
`default_nettype none

// Wired bus, an undriven bus reads as zero
module internalBus #(
    parameter int INPUT_COUNT = 2
) (
    input  logic [INPUT_COUNT-1:0]      busSelect,
    input  logic [INPUT_COUNT-1:0][7:0] busInputs,
    output logic [7:0]                  busOutput
);

    always_comb begin
        busOutput = 8'h00;
        for (int i = 0; i < INPUT_COUNT; i++) begin
            if (busSelect[i]) begin
                busOutput = busOutput | busInputs[i]; // Open drain merge
            end
        end
    end

endmodule

`default_nettype wire

/* design/internalDataflow.sv */
`timescale 1ns/1ps
`default_nettype none

module internalDataflow (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  microValid,
    input  dataflowPkg::microOp_u microOp,
    input  logic [7:0]            externalDBRead,
    output logic [7:0]            externalDBWrite,
    output logic [7:0]            addressLow,
    output logic [7:0]            addressHigh,
    output dataflowPkg::psrBits_t psr
);

    dataflowPkg::controlFlags_t flags;

    logic [7:0]  xReg, yReg, accReg, spReg, aluReg, dorReg, ablReg, abhReg;
    logic [7:0]  dbDriven, sbDriven, adhDriven; // Before the bridge
    logic [7:0]  dataBus, stackBus, addressLowBus, addressHighBus;
    logic [7:0]  aluResult;
    logic        aluCarry, aluOverflow;
    logic [15:0] pc;

    assign externalDBWrite = dorReg;
    assign addressLow      = ablReg;
    assign addressHigh     = abhReg;

    microDecoder decoder_i (
        .clk(clk), .reset(reset), .microValid(microValid), .microOp(microOp), .flags(flags)
    );

    internalBus #(.INPUT_COUNT(6)) dataBus_i (
        .busSelect(flags.dbSelect),
        .busInputs({pc[15:8], pc[7:0], accReg, psr, externalDBRead, flags.presetValue}),
        .busOutput(dbDriven)
    );

    internalBus #(.INPUT_COUNT(6)) stackBus_i (
        .busSelect(flags.sbSelect),
        .busInputs({flags.presetValue, aluReg, spReg, accReg, yReg, xReg}),
        .busOutput(sbDriven)
    );

    internalBus #(.INPUT_COUNT(4)) addressLowBus_i (
        .busSelect(flags.adlSelect),
        .busInputs({aluReg, spReg, externalDBRead, flags.presetValue}),
        .busOutput(addressLowBus)
    );

    internalBus #(.INPUT_COUNT(2)) addressHighBus_i (
        .busSelect(flags.adhSelect),
        .busInputs({externalDBRead, flags.presetValue}),
        .busOutput(adhDriven)
    );

    busBridge bridge_i (
        .dbIn(dbDriven), .sbIn(sbDriven), .adhIn(adhDriven), .flags(flags),
        .dataBus(dataBus), .stackBus(stackBus), .addressHighBus(addressHighBus)
    );

    alu alu_i (
        .stackBus(stackBus), .dataBus(dataBus), .psrCarry(psr.c), .flags(flags),
        .result(aluResult), .carryOut(aluCarry), .overflow(aluOverflow)
    );

    programCounter pc_i (
        .clk(clk), .reset(reset), .flags(flags), .loadAddress({abhReg, ablReg}), .pc(pc)
    );

    statusRegister psr_i (
        .clk(clk), .reset(reset), .flags(flags), .dataBus(dataBus),
        .aluResult(aluResult), .carry(aluCarry), .overflow(aluOverflow), .psr(psr)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            xReg   <= 8'h00;
            yReg   <= 8'h00;
            accReg <= 8'h00;
            spReg  <= 8'h00;
            aluReg <= 8'h00;
            dorReg <= 8'h00;
            ablReg <= 8'h00;
            abhReg <= 8'h00;
        end else begin
            if (flags.loadX)   xReg   <= stackBus;
            if (flags.loadY)   yReg   <= stackBus;
            if (flags.loadAcc) accReg <= stackBus;
            if (flags.loadSp)  spReg  <= stackBus;
            if (flags.loadAlu) aluReg <= aluResult;
            if (flags.loadDor) dorReg <= dataBus;
            // PC copy overrides any bus load of the latches
            if (flags.pcToAddress) begin
                ablReg <= pc[7:0];
                abhReg <= pc[15:8];
            end else begin
                if (flags.loadAbl) ablReg <= addressLowBus;
                if (flags.loadAbh) abhReg <= addressHighBus;
            end
        end
    end

endmodule

`default_nettype wire

/* design/microDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module microDecoder (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       microValid,
    input  dataflowPkg::microOp_u      microOp,
    output dataflowPkg::controlFlags_t flags
);

    dataflowPkg::controlFlags_t next;
    dataflowPkg::transferOp_t   xfer;
    dataflowPkg::aluOp_t        aluOp;
    logic [5:0]                 srcSb, srcDb;

    assign xfer  = microOp.transfer;
    assign aluOp = microOp.alu;

    // Where the source can drive SB or DB directly
    always_comb begin
        srcSb = 6'b000000;
        srcDb = 6'b000000;
        case (xfer.source)
            dataflowPkg::SRC_X:    srcSb = 6'b000001;
            dataflowPkg::SRC_Y:    srcSb = 6'b000010;
            dataflowPkg::SRC_SP:   srcSb = 6'b001000;
            dataflowPkg::SRC_ALU:  srcSb = 6'b010000;
            dataflowPkg::SRC_DATA: srcDb = 6'b000010;
            dataflowPkg::SRC_PSR:  srcDb = 6'b000100;
            dataflowPkg::SRC_ACC: begin
                srcSb = 6'b000100;
                srcDb = 6'b001000;
            end
            default: begin // Preset
                srcSb = 6'b100000;
                srcDb = 6'b000001;
            end
        endcase
    end

    always_comb begin
        next = '0;
        if (aluOp.kind) begin
            next.loadAlu   = 1'b1;
            next.dbSelect  = 6'b000010; // B operand from DATA
            next.func      = aluOp.func;
            next.aSel      = aluOp.aSel;
            next.bInvert   = aluOp.bInvert;
            next.carrySel  = aluOp.carrySel;
            next.flagWrite = aluOp.flagWrite;
            next.pcInc     = aluOp.pcInc;
            if (aluOp.aSel != dataflowPkg::A_ZERO) begin
                next.sbSelect = 6'b000001 << aluOp.aSel;
            end
        end else begin
            next.pcInc       = xfer.pcInc;
            next.pcLoad      = xfer.pcLoad;
            next.pcToAddress = xfer.pcToAddress;
            case (xfer.preset)
                dataflowPkg::PRESET_FF: next.presetValue = 8'hFF;
                dataflowPkg::PRESET_FE: next.presetValue = 8'hFE;
                dataflowPkg::PRESET_FA: next.presetValue = 8'hFA;
                default:                next.presetValue = 8'h00;
            endcase
            case (xfer.dest)
                dataflowPkg::DST_DOR, dataflowPkg::DST_PSR: begin
                    if (srcDb != 6'b000000) begin
                        next.dbSelect = srcDb;
                    end else begin
                        next.sbSelect = srcSb;
                        next.sbToDb   = 1'b1;
                    end
                    next.loadDor = (xfer.dest == dataflowPkg::DST_DOR);
                    next.loadPsr = (xfer.dest == dataflowPkg::DST_PSR);
                end
                dataflowPkg::DST_ABL: begin
                    case (xfer.source)
                        dataflowPkg::SRC_PRESET: next.adlSelect = 4'b0001;
                        dataflowPkg::SRC_DATA:   next.adlSelect = 4'b0010;
                        dataflowPkg::SRC_SP:     next.adlSelect = 4'b0100;
                        dataflowPkg::SRC_ALU:    next.adlSelect = 4'b1000;
                        default:                 next.adlSelect = 4'b0000;
                    endcase
                    next.loadAbl = (next.adlSelect != 4'b0000); // Other sources are no-ops
                end
                dataflowPkg::DST_ABH: begin
                    next.loadAbh = 1'b1;
                    if (xfer.source == dataflowPkg::SRC_PRESET) begin
                        next.adhSelect = 2'b01;
                    end else if (xfer.source == dataflowPkg::SRC_DATA) begin
                        next.adhSelect = 2'b10;
                    end else if (srcSb != 6'b000000) begin
                        next.sbSelect = srcSb;
                        next.sbToAdh  = 1'b1;
                    end else begin
                        next.dbSelect = srcDb; // PSR takes DB, SB, then ADH
                        next.dbToSb   = 1'b1;
                        next.sbToAdh  = 1'b1;
                    end
                end
                default: begin // X, Y, ACC, SP
                    if (srcSb != 6'b000000) begin
                        next.sbSelect = srcSb;
                    end else begin
                        next.dbSelect = srcDb;
                        next.dbToSb   = 1'b1;
                    end
                    next.loadX   = (xfer.dest == dataflowPkg::DST_X);
                    next.loadY   = (xfer.dest == dataflowPkg::DST_Y);
                    next.loadAcc = (xfer.dest == dataflowPkg::DST_ACC);
                    next.loadSp  = (xfer.dest == dataflowPkg::DST_SP);
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !microValid) begin
            flags <= '0; // No-op cycle
        end else begin
            flags <= next;
        end
    end

endmodule

`default_nettype wire

/* design/programCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module programCounter (
    input  logic                       clk,
    input  logic                       reset,
    input  dataflowPkg::controlFlags_t flags,
    input  logic [15:0]                loadAddress,
    output logic [15:0]                pc
);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= 16'h0000;
        end else if (flags.pcLoad) begin
            pc <= loadAddress; // Jump wins over increment
        end else if (flags.pcInc) begin
            pc <= pc + 16'd1;  // Wraps at FFFF
        end
    end

endmodule

`default_nettype wire

/* design/statusRegister.sv */
`timescale 1ns/1ps
`default_nettype none

module statusRegister (
    input  logic                       clk,
    input  logic                       reset,
    input  dataflowPkg::controlFlags_t flags,
    input  logic [7:0]                 dataBus,
    input  logic [7:0]                 aluResult,
    input  logic                       carry,
    input  logic                       overflow,
    output dataflowPkg::psrBits_t      psr
);

    always_ff @(posedge clk) begin
        if (reset) begin
            psr <= '{one: 1'b1, default: 1'b0};
        end else if (flags.loadPsr) begin
            // Whole byte from DB, D and I included
            psr     <= dataflowPkg::psrBits_t'(dataBus);
            psr.one <= 1'b1;
        end else if (flags.flagWrite) begin
            psr.n <= aluResult[7];
            psr.z <= (aluResult == 8'h00);
            psr.c <= carry;
            psr.v <= overflow;
        end
    end

endmodule

`default_nettype wire

/* internalDataflow.f */
design/dataflowPkg.sv
design/internalBus.sv
design/busBridge.sv
design/programCounter.sv
design/alu.sv
design/statusRegister.sv
design/microDecoder.sv
design/internalDataflow.sv
sim/internalDataflowTb.sv

/* run.sh */
#!/bin/sh
# Build and run the internalDataflow testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module internalDataflowTb -f internalDataflow.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VinternalDataflowTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q 'All tests passed!' sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi

/* sim/internalDataflowTb.sv */
`timescale 1ns/1ps
`default_nettype none

module internalDataflowTb;

    localparam int RESET_CYCLES = 16;
    localparam int ALU_TESTS    = 30;
    localparam int RANDOM_OPS   = 300;
    // Cycles per test: reset 3, transfers 6, ALU 4 each plus 2, PC at most 33, random plus 2,
    // PSR 8, closing 2
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 3 + 6 + ALU_TESTS * 4 + 2 + 33
                                  + RANDOM_OPS + 2 + 8 + 2 + 64;

    typedef struct packed {
        logic [7:0]  x;
        logic [7:0]  y;
        logic [7:0]  acc;
        logic [7:0]  sp;
        logic [7:0]  hold;
        logic [7:0]  dor;
        logic [7:0]  abl;
        logic [7:0]  abh;
        logic [15:0] pc;
        logic [7:0]  psr;
    } modelState_t;

    logic                  clk;
    logic                  reset;
    logic                  microValid;
    dataflowPkg::microOp_u microOp;
    logic [7:0]            externalDBRead;
    logic [7:0]            externalDBWrite;
    logic [7:0]            addressLow;
    logic [7:0]            addressHigh;
    dataflowPkg::psrBits_t psr;

    modelState_t           model;
    logic                  pendingValid;
    dataflowPkg::microOp_u pendingOp;
    logic [31:0]           lcgState = 32'd13;
    int                    errorCount = 0;
    int                    checkCount = 0;
    int                    cycleCount = 0;

    internalDataflow dut_i (
        .clk(clk), .reset(reset), .microValid(microValid), .microOp(microOp),
        .externalDBRead(externalDBRead), .externalDBWrite(externalDBWrite),
        .addressLow(addressLow), .addressHigh(addressHigh), .psr(psr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [15:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31:16]; // Upper half has the longer period
    endfunction

    function automatic logic [11:0] move(input logic [2:0] source, input logic [2:0] dest);
        return {1'b0, source, dest, 2'b11, 3'b000};
    endfunction

    function automatic logic [11:0] presetTo(input logic [2:0] dest, input logic [1:0] sel);
        return {1'b0, dataflowPkg::SRC_PRESET, dest, sel, 3'b000};
    endfunction

    // X to ABL is an unsupported pair, so only the PC bits act
    function automatic logic [11:0] pcOp(input logic inc, input logic toAddr, input logic load);
        return {1'b0, dataflowPkg::SRC_X, dataflowPkg::DST_ABL, 2'b11, inc, toAddr, load};
    endfunction

    function automatic logic [11:0] aluWord(input logic [2:0] func, input logic [1:0] aSel,
            input logic bInvert, input logic [1:0] carrySel);
        return {1'b1, func, aSel, bInvert, carrySel, 1'b1, 1'b0, 1'b0};
    endfunction

    // Expected state one edge after an op has been latched
    function automatic modelState_t refStep(input modelState_t s, input logic valid,
            input dataflowPkg::microOp_u op, input logic [7:0] data);
        modelState_t n;
        logic [7:0]  srcVal;
        logic [7:0]  aVal;
        logic [7:0]  bVal;
        logic        cin;
        logic [8:0]  sum;
        logic [7:0]  res;
        logic        cout;
        logic        ovf;
        n = s;
        srcVal = 8'h00;
        if (!valid) begin
            return n;
        end
        if (!op.alu.kind) begin
            case (op.transfer.source)
                dataflowPkg::SRC_X:    srcVal = s.x;
                dataflowPkg::SRC_Y:    srcVal = s.y;
                dataflowPkg::SRC_ACC:  srcVal = s.acc;
                dataflowPkg::SRC_SP:   srcVal = s.sp;
                dataflowPkg::SRC_DATA: srcVal = data;
                dataflowPkg::SRC_ALU:  srcVal = s.hold;
                dataflowPkg::SRC_PSR:  srcVal = s.psr;
                default: begin
                    case (op.transfer.preset)
                        dataflowPkg::PRESET_FF: srcVal = 8'hFF;
                        dataflowPkg::PRESET_FE: srcVal = 8'hFE;
                        dataflowPkg::PRESET_FA: srcVal = 8'hFA;
                        default:                srcVal = 8'h00;
                    endcase
                end
            endcase
            case (op.transfer.dest)
                dataflowPkg::DST_X:   n.x = srcVal;
                dataflowPkg::DST_Y:   n.y = srcVal;
                dataflowPkg::DST_ACC: n.acc = srcVal;
                dataflowPkg::DST_SP:  n.sp = srcVal;
                dataflowPkg::DST_DOR: n.dor = srcVal;
                dataflowPkg::DST_PSR: n.psr = srcVal | 8'h20; // Bit 5 is wired high
                dataflowPkg::DST_ABL: begin
                    // Only sources with an ADL path
                    if (op.transfer.source inside {dataflowPkg::SRC_PRESET, dataflowPkg::SRC_DATA,
                            dataflowPkg::SRC_SP, dataflowPkg::SRC_ALU}) begin
                        n.abl = srcVal;
                    end
                end
                default: n.abh = srcVal;
            endcase
            if (op.transfer.pcToAddress) begin
                n.abl = s.pc[7:0];
                n.abh = s.pc[15:8];
            end
            if (op.transfer.pcLoad) begin
                n.pc = {s.abh, s.abl};
            end else if (op.transfer.pcInc) begin
                n.pc = s.pc + 16'd1;
            end
        end else begin
            case (op.alu.aSel)
                dataflowPkg::A_X:   aVal = s.x;
                dataflowPkg::A_Y:   aVal = s.y;
                dataflowPkg::A_ACC: aVal = s.acc;
                default:            aVal = 8'h00;
            endcase
            bVal = (op.alu.bInvert || op.alu.func == dataflowPkg::ALU_SUB) ? ~data : data;
            case (op.alu.carrySel)
                dataflowPkg::CARRY_ONE: cin = 1'b1;
                dataflowPkg::CARRY_PSR: cin = s.psr[0];
                default:                cin = 1'b0;
            endcase
            sum = {1'b0, aVal} + {1'b0, bVal} + {8'h00, cin};
            cout = 1'b0;
            ovf = 1'b0;
            case (op.alu.func)
                dataflowPkg::ALU_ADD, dataflowPkg::ALU_SUB: begin
                    res  = sum[7:0];
                    cout = sum[8];
                    ovf  = (aVal[7] ~^ bVal[7]) & (aVal[7] ^ sum[7]);
                end
                dataflowPkg::ALU_AND: res = aVal & bVal;
                dataflowPkg::ALU_OR:  res = aVal | bVal;
                dataflowPkg::ALU_XOR: res = aVal ^ bVal;
                dataflowPkg::ALU_SHR: begin
                    res  = aVal >> 1;
                    cout = aVal[0];
                end
                default: res = 8'h00;
            endcase
            n.hold = res;
            if (op.alu.flagWrite) begin
                n.psr[7] = res[7];
                n.psr[6] = ovf;
                n.psr[1] = (res == 8'h00);
                n.psr[0] = cout;
            end
            if (op.alu.pcInc) begin
                n.pc = s.pc + 16'd1;
            end
        end
        return n;
    endfunction

    task automatic checkByte(input string name, input logic [7:0] got,
            input logic [7:0] expected);
        checkCount++;
        assert (got === expected) else begin
            $display("Fail at %0t ns: %s is %02h, expected %02h", $time, name, got, expected);
            errorCount++;
        end
    endtask

    // Outputs read before this edge's register updates
    always @(posedge clk) begin
        if (reset) begin
            model = '0;
            model.psr = 8'h20;
            pendingValid = 1'b0;
            pendingOp = '0;
        end else begin
            checkByte("externalDBWrite", externalDBWrite, model.dor);
            checkByte("addressLow", addressLow, model.abl);
            checkByte("addressHigh", addressHigh, model.abh);
            checkByte("psr", psr, model.psr);
            model = refStep(model, pendingValid, pendingOp, externalDBRead);
            pendingValid = microValid;
            pendingOp = microOp;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("Test failures found");
            $display("Timeout after %0d cycles, the test sequence did not finish", cycleCount);
            $finish;
        end
    end

    task automatic drive(input logic valid, input logic [11:0] word, input logic [7:0] data);
        @(negedge clk);
        microValid = valid;
        microOp = word;
        externalDBRead = data;
    endtask

    task automatic idle(input int cycles, input logic [7:0] data);
        repeat (cycles) drive(1'b0, 12'h000, data);
    endtask

    task automatic reportTest(input int number, input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            $display("Test %0d %s: ok", number, name);
        end else begin
            $display("Test %0d %s: %0d errors", number, name, errorCount - errorsBefore);
        end
    endtask

    task automatic testAlu();
        logic [15:0] r;
        logic [7:0]  a;
        logic [7:0]  b;
        logic [1:0]  aSel;
        logic [2:0]  loadDest;
        for (int i = 0; i < ALU_TESTS; i++) begin
            r = nextRandom();
            a = r[15:8];
            b = r[7:0];
            r = nextRandom();
            aSel = r[1:0];
            loadDest = (aSel == 2'd3) ? 3'd0 : {1'b0, aSel}; // A_X, A_Y, A_ACC match the dest codes
            drive(1'b1, move(dataflowPkg::SRC_DATA, loadDest), a);
            drive(1'b1, aluWord(3'(i % 6), aSel, r[2], 2'(r[7:4] % 4'd3)), a);
            drive(1'b1, move(dataflowPkg::SRC_ALU, dataflowPkg::DST_X), b);
            drive(1'b1, move(dataflowPkg::SRC_X, dataflowPkg::DST_DOR), b);
        end
        idle(2, 8'h00);
    endtask

    task automatic testProgramCounter();
        int          steps;
        logic [15:0] count;
        steps = 5 + int'(nextRandom() % 16'd8);
        count = 16'(steps);
        drive(1'b1, presetTo(dataflowPkg::DST_ABL, dataflowPkg::PRESET_00), 8'h00);
        drive(1'b1, presetTo(dataflowPkg::DST_ABH, dataflowPkg::PRESET_00), 8'h00);
        drive(1'b1, pcOp(1'b0, 1'b0, 1'b1), 8'h00);
        repeat (steps) drive(1'b1, pcOp(1'b1, 1'b0, 1'b0), 8'h00);
        drive(1'b1, pcOp(1'b0, 1'b1, 1'b0), 8'h00);
        idle(2, 8'h00);
        checkByte("addressLow", addressLow, count[7:0]);
        checkByte("addressHigh", addressHigh, count[15:8]);
        // Jump to FEFA then count two
        drive(1'b1, presetTo(dataflowPkg::DST_ABL, dataflowPkg::PRESET_FA), 8'h00);
        drive(1'b1, presetTo(dataflowPkg::DST_ABH, dataflowPkg::PRESET_FE), 8'h00);
        drive(1'b1, pcOp(1'b0, 1'b0, 1'b1), 8'h00);
        drive(1'b1, pcOp(1'b1, 1'b0, 1'b0), 8'h00);
        drive(1'b1, pcOp(1'b1, 1'b0, 1'b0), 8'h00);
        drive(1'b1, pcOp(1'b0, 1'b1, 1'b0), 8'h00);
        idle(2, 8'h00);
        checkByte("addressLow", addressLow, 8'hFC);
        checkByte("addressHigh", addressHigh, 8'hFE);
        // Wrap from FFFF
        drive(1'b1, presetTo(dataflowPkg::DST_ABL, dataflowPkg::PRESET_FF), 8'h00);
        drive(1'b1, presetTo(dataflowPkg::DST_ABH, dataflowPkg::PRESET_FF), 8'h00);
        drive(1'b1, pcOp(1'b0, 1'b0, 1'b1), 8'h00);
        drive(1'b1, pcOp(1'b1, 1'b0, 1'b0), 8'h00);
        drive(1'b1, pcOp(1'b0, 1'b1, 1'b0), 8'h00);
        idle(2, 8'h00);
        checkByte("addressLow", addressLow, 8'h00);
        checkByte("addressHigh", addressHigh, 8'h00);
    endtask

    task automatic testRandom();
        logic [15:0] r;
        logic [15:0] s;
        logic [15:0] d;
        logic [11:0] word;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r = nextRandom();
            s = nextRandom();
            d = nextRandom();
            word = s[11:0];
            if (word[11]) begin
                word[10:8] = 3'(r[15:8] % 8'd6); // Valid ALU functions only
                word[4:3]  = 2'(r[7:4] % 4'd3);
            end
            drive(r[1:0] != 2'b00, word, d[7:0]); // Strobe low one cycle in four
        end
        idle(2, 8'h00);
    endtask

    task automatic testPsrLoad(input logic [7:0] data);
        drive(1'b1, move(dataflowPkg::SRC_DATA, dataflowPkg::DST_PSR), data);
        drive(1'b1, move(dataflowPkg::SRC_PSR, dataflowPkg::DST_DOR), data);
        idle(2, data);
        checkByte("psr", psr, data | 8'h20);
        checkByte("externalDBWrite", externalDBWrite, data | 8'h20);
    endtask

    initial begin
        int errorsBefore;
        reset = 1'b1;
        microValid = 1'b0;
        microOp = '0;
        externalDBRead = 8'h00;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        errorsBefore = errorCount;
        idle(2, 8'h00);
        checkByte("externalDBWrite", externalDBWrite, 8'h00);
        checkByte("addressLow", addressLow, 8'h00);
        checkByte("addressHigh", addressHigh, 8'h00);
        checkByte("psr", psr, 8'h20);
        reportTest(1, "reset values", errorsBefore);

        errorsBefore = errorCount;
        drive(1'b1, move(dataflowPkg::SRC_DATA, dataflowPkg::DST_X), 8'h5C);
        drive(1'b1, move(dataflowPkg::SRC_X, dataflowPkg::DST_DOR), 8'h5C);
        drive(1'b1, presetTo(dataflowPkg::DST_ABL, dataflowPkg::PRESET_FA), 8'h5C);
        drive(1'b1, presetTo(dataflowPkg::DST_ABH, dataflowPkg::PRESET_FE), 8'h5C);
        idle(2, 8'h5C);
        checkByte("externalDBWrite", externalDBWrite, 8'h5C);
        checkByte("addressLow", addressLow, 8'hFA);
        checkByte("addressHigh", addressHigh, 8'hFE);
        reportTest(2, "transfers and presets", errorsBefore);

        errorsBefore = errorCount;
        testAlu();
        reportTest(3, "ALU functions and flags", errorsBefore);

        errorsBefore = errorCount;
        testProgramCounter();
        reportTest(4, "program counter", errorsBefore);

        errorsBefore = errorCount;
        testRandom();
        reportTest(5, "random stream", errorsBefore);

        errorsBefore = errorCount;
        testPsrLoad(8'h0C);
        testPsrLoad(8'hC3);
        reportTest(6, "PSR load", errorsBefore);

        idle(2, 8'h00);
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
